/* fetch_defs.svh */
// Fetch front-end configuration macros
// Reset vector, instruction cache size and byte address width

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_1000

// Number of direct-mapped cache lines, a power of two
`define ICACHE_LINES 16

// Byte address width of the front end
`define FETCH_ADDR_W 32

`endif

/* fetch_pkg.sv */
// Core-side fetch types
// Byte address and instruction word types
// Fetch request and response between PC generator and cache interface
// Fetched word record handed to decode

`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] addr_t;
    typedef logic [31:0] instr_t;

    // Word request from the PC generator
    typedef struct packed {
        logic  valid;
        addr_t vaddr;
        logic  invalidate_buffer;  // redirect in this cycle
    } req_cpu_icache_t;

    // Word answer from the cache interface
    typedef struct packed {
        logic   valid;
        instr_t data;
        logic   access_fault;
    } resp_icache_cpu_t;

    // Output towards decode
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
        logic   access_fault;
    } fetch_out_t;

endpackage

`default_nettype wire

/* icache_pkg.sv */
// Cache-side types of the fetch front end
// Line, line address, index and tag types
// Cache interface FSM states
// Request and response between cache interface and cache array
// APB3 master request and response

`default_nettype none

`include "fetch_defs.svh"

package icache_pkg;

    typedef logic [127:0] icache_line_t;
    typedef logic [`FETCH_ADDR_W-5:0] line_addr_t;
    typedef logic [$clog2(`ICACHE_LINES)-1:0] icache_idx_t;
    typedef logic [`FETCH_ADDR_W-5-$clog2(`ICACHE_LINES):0] icache_tag_t;

    typedef enum logic [1:0] {
        NoReq,
        ReqValid,
        Replay
    } icache_state_t;

    typedef struct packed {
        logic       valid;
        line_addr_t line;
    } icache_req_t;

    // Single-cycle pulse tagged with the line it answers
    typedef struct packed {
        logic         valid;
        line_addr_t   line;
        icache_line_t data;
        logic         error;
    } icache_resp_t;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [`FETCH_ADDR_W-1:0] paddr;
        logic [31:0]              pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_resp_t;

endpackage

`default_nettype wire

/* pc_gen.sv */
// PC generator
// Fetch PC register, sequential advance, redirect and stall
// Builds the fetched word record for decode

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module pc_gen import fetch_pkg::*; (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             stall_i,
    input  logic             redirect_valid_i,
    input  addr_t            redirect_pc_i,
    input  resp_icache_cpu_t resp_i,
    output req_cpu_icache_t  req_o,
    output fetch_out_t       fetch_o
);

    addr_t pc_q;
    addr_t pc_d;
    logic  run_q;
    logic  advance;

    // A word is consumed when it arrives and decode does not hold
    assign advance = resp_i.valid & ~stall_i;

    always_comb begin
        pc_d = pc_q;
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (advance) begin
            pc_d = pc_q + addr_t'(4);
        end
    end

    // Requests start one cycle after reset is released
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q  <= `FETCH_RESET_PC;
            run_q <= 1'b0;
        end else begin
            pc_q  <= pc_d;
            run_q <= 1'b1;
        end
    end

    assign req_o.valid             = run_q;
    assign req_o.vaddr             = pc_q;
    assign req_o.invalidate_buffer = redirect_valid_i;

    // Old-path word is dropped in the redirect cycle
    assign fetch_o.valid        = resp_i.valid & ~redirect_valid_i;
    assign fetch_o.pc           = pc_q;
    assign fetch_o.instr        = resp_i.data;
    assign fetch_o.access_fault = resp_i.access_fault;

endmodule

`default_nettype wire

/* icache_interface.sv */
// Fetch-side cache interface
// Line buffer holding the last returned cache line
// NoReq/ReqValid/Replay FSM issuing one cache request per buffer miss
// Word select and access fault reporting towards the PC generator

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module icache_interface import fetch_pkg::*, icache_pkg::*; (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  req_cpu_icache_t  req_fetch_i,
    input  logic             icache_req_ready_i,
    input  icache_resp_t     icache_resp_i,
    output icache_req_t      icache_req_o,
    output resp_icache_cpu_t resp_fetch_o
);

    icache_state_t state_q;
    icache_state_t state_d;

    icache_line_t  buf_line_q;
    line_addr_t    buf_addr_q;
    logic          buf_valid_q;
    // Line of the request in flight
    line_addr_t    pend_line_q;

    line_addr_t    req_line;
    icache_line_t  line_sel;
    logic          buf_hit;
    logic          resp_match;
    logic          do_request;
    logic          line_changed;
    logic          fill_buf;

    assign req_line     = req_fetch_i.vaddr[`FETCH_ADDR_W-1:4];
    assign buf_hit      = buf_valid_q & (buf_addr_q == req_line);
    assign resp_match   = icache_resp_i.valid & (icache_resp_i.line == req_line);
    assign line_changed = pend_line_q != req_line;

    // No request on a redirect since the PC is about to change
    assign do_request = req_fetch_i.valid & ~buf_hit & ~req_fetch_i.invalidate_buffer
                      & icache_req_ready_i;

    // Faulty lines never enter the buffer
    assign fill_buf = resp_match & ~icache_resp_i.error & ~req_fetch_i.invalidate_buffer;

    always_comb begin
        state_d = state_q;
        case (state_q)
            NoReq: begin
                if (do_request) begin
                    state_d = ReqValid;
                end
            end
            ReqValid: begin
                if (req_fetch_i.invalidate_buffer || line_changed || resp_match) begin
                    state_d = NoReq;
                end else if (!icache_req_ready_i) begin
                    // Cache busy with a refill
                    state_d = Replay;
                end
            end
            Replay: begin
                if (req_fetch_i.invalidate_buffer || line_changed || resp_match
                    || icache_req_ready_i) begin
                    state_d = NoReq;
                end
            end
            default: begin
                state_d = NoReq;
            end
        endcase
    end

    assign icache_req_o.valid = (state_q == NoReq) & do_request;
    assign icache_req_o.line  = req_line;

    // Buffer wins when both hold the line
    assign line_sel = buf_hit ? buf_line_q : icache_resp_i.data;

    always_comb begin
        resp_fetch_o.valid        = req_fetch_i.valid & ~req_fetch_i.invalidate_buffer
                                  & (buf_hit | resp_match);
        resp_fetch_o.access_fault = ~buf_hit & resp_match & icache_resp_i.error;
        if (resp_fetch_o.access_fault) begin
            resp_fetch_o.data = '0;
        end else begin
            case (req_fetch_i.vaddr[3:2])
                2'b00:   resp_fetch_o.data = line_sel[31:0];
                2'b01:   resp_fetch_o.data = line_sel[63:32];
                2'b10:   resp_fetch_o.data = line_sel[95:64];
                default: resp_fetch_o.data = line_sel[127:96];
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= NoReq;
            buf_valid_q <= 1'b0;
            pend_line_q <= '0;
        end else begin
            state_q <= state_d;
            if (req_fetch_i.invalidate_buffer) begin
                buf_valid_q <= 1'b0;
            end else if (fill_buf) begin
                buf_valid_q <= 1'b1;
            end
            if (icache_req_o.valid) begin
                pend_line_q <= req_line;
            end
        end
    end

    // Line payload qualified by buf_valid_q
    always_ff @(posedge clk_i) begin
        if (fill_buf) begin
            buf_line_q <= icache_resp_i.data;
            buf_addr_q <= req_line;
        end
    end

endmodule

`default_nettype wire

/* icache_array.sv */
// Direct-mapped instruction cache array
// Line data, tags and valid bits with flush
// Four-beat APB3 refill engine for missed lines

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module icache_array import icache_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  logic         flush_i,
    input  icache_req_t  req_i,
    output logic         req_ready_o,
    output icache_resp_t resp_o,
    output apb_req_t     apb_req_o,
    input  apb_resp_t    apb_resp_i
);

    typedef enum logic [2:0] {
        Idle,
        Lookup,
        Setup,
        Access,
        Respond
    } array_state_t;

    array_state_t             state_q;
    icache_line_t             data_q [`ICACHE_LINES];
    icache_tag_t              tag_q [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] valid_q;

    line_addr_t   line_q;
    icache_line_t fill_q;
    logic [1:0]   beat_q;
    // Sticky slave error over the four beats
    logic         err_q;

    icache_idx_t  idx;
    icache_tag_t  tag;
    logic         hit;
    logic         accept;
    logic         beat_done;
    logic         install;

    assign idx       = line_q[$bits(icache_idx_t)-1:0];
    assign tag       = line_q[$bits(line_addr_t)-1:$bits(icache_idx_t)];
    assign hit       = valid_q[idx] & (tag_q[idx] == tag);
    assign beat_done = (state_q == Access) & apb_resp_i.pready;
    assign install   = (state_q == Respond) & ~err_q;

    // A flush blocks acceptance for its cycle
    assign req_ready_o = (state_q == Idle) & ~flush_i;
    assign accept      = req_i.valid & req_ready_o;

    assign resp_o.valid = ((state_q == Lookup) & hit) | (state_q == Respond);
    assign resp_o.line  = line_q;
    assign resp_o.data  = (state_q == Respond) ? fill_q : data_q[idx];
    assign resp_o.error = (state_q == Respond) & err_q;

    // Read-only master, one word per transfer
    assign apb_req_o.psel    = (state_q == Setup) | (state_q == Access);
    assign apb_req_o.penable = state_q == Access;
    assign apb_req_o.pwrite  = 1'b0;
    assign apb_req_o.paddr   = {line_q, beat_q, 2'b00};
    assign apb_req_o.pwdata  = '0;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= Idle;
            valid_q <= '0;
            beat_q  <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                Idle: begin
                    if (accept) begin
                        state_q <= Lookup;
                    end
                end
                Lookup: begin
                    state_q <= hit ? Idle : Setup;
                    beat_q  <= '0;
                    err_q   <= 1'b0;
                end
                Setup: begin
                    state_q <= Access;
                end
                Access: begin
                    if (apb_resp_i.pready) begin
                        err_q   <= err_q | apb_resp_i.pslverr;
                        beat_q  <= beat_q + 2'd1;
                        state_q <= (beat_q == 2'd3) ? Respond : Setup;
                    end
                end
                default: begin
                    state_q <= Idle;
                end
            endcase
            if (flush_i) begin
                valid_q <= '0;
            end else if (install) begin
                valid_q[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            line_q <= req_i.line;
        end
        if (beat_done) begin
            fill_q[{beat_q, 5'b0} +: 32] <= apb_resp_i.prdata;
        end
        if (install) begin
            data_q[idx] <= fill_q;
            tag_q[idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

/* fetch_top.sv */
// Instruction fetch front end
// PC generator, fetch-side cache interface and cache array
// APB master port for line refills

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*, icache_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       stall_i,
    input  logic       redirect_valid_i,
    input  addr_t      redirect_pc_i,
    input  logic       flush_i,
    output fetch_out_t fetch_o,
    output apb_req_t   apb_req_o,
    input  apb_resp_t  apb_resp_i
);

    req_cpu_icache_t  fetch_req;
    resp_icache_cpu_t fetch_resp;
    icache_req_t      icache_req;
    icache_resp_t     icache_resp;
    logic             icache_req_ready;

    pc_gen u_pc_gen (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .resp_i           (fetch_resp),
        .req_o            (fetch_req),
        .fetch_o          (fetch_o)
    );

    icache_interface u_icache_interface (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .req_fetch_i        (fetch_req),
        .icache_req_ready_i (icache_req_ready),
        .icache_resp_i      (icache_resp),
        .icache_req_o       (icache_req),
        .resp_fetch_o       (fetch_resp)
    );

    icache_array u_icache_array (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .req_i       (icache_req),
        .req_ready_o (icache_req_ready),
        .resp_o      (icache_resp),
        .apb_req_o   (apb_req_o),
        .apb_resp_i  (apb_resp_i)
    );

endmodule

`default_nettype wire

/* tb_fetch_top.sv */
// Testbench for the instruction fetch front end
// Clock, reset, APB memory model with random wait states
// Sequential fetch, refill count, redirect, flush, access fault and stall tests

`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module tb_fetch_top import fetch_pkg::*, icache_pkg::*;;

    localparam int TIMEOUT = 400;

    logic       clk_i;
    logic       rstn_i;
    logic       stall_i;
    logic       redirect_valid_i;
    addr_t      redirect_pc_i;
    logic       flush_i;
    fetch_out_t fetch_o;
    apb_req_t   apb_req_o;
    apb_resp_t  apb_resp_i;

    int          errors;
    int          checks;
    int          apb_transfers;
    int          wait_cnt;
    logic [31:0] apb_rng;
    logic [31:0] stall_rng;
    logic        stall_mode;
    logic        hold_prev;
    fetch_out_t  prev_fetch;
    apb_req_t    setup_req;

    fetch_top uut (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .flush_i          (flush_i),
        .fetch_o          (fetch_o),
        .apb_req_o        (apb_req_o),
        .apb_resp_i       (apb_resp_i)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // The line at 0x3000 answers with a slave error
    function automatic logic is_fault_line(input addr_t pc);
        return pc[31:4] == 28'h000_0300;
    endfunction

    function automatic instr_t model_word(input addr_t pc);
        return is_fault_line(pc) ? 32'h0 : pc ^ 32'h5a5a_0000;
    endfunction

    task automatic compare_value(input string name, input logic [65:0] got,
                                 input logic [65:0] expected);
        checks++;
        assert (got == expected) else begin
            $display("error %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // APB memory model driving its response 1 ns after the rising edge
    always @(posedge clk_i) begin
        #1;
        if (apb_req_o.psel && apb_req_o.penable) begin
            // Address and write data hold through the access phase
            compare_value("apb_req_o.paddr", apb_req_o.paddr, setup_req.paddr);
            compare_value("apb_req_o.pwdata", apb_req_o.pwdata, setup_req.pwdata);
            if (wait_cnt == 0) begin
                apb_resp_i.pready  = 1'b1;
                apb_resp_i.prdata  = apb_req_o.paddr ^ 32'h5a5a_0000;
                apb_resp_i.pslverr = is_fault_line(apb_req_o.paddr);
                apb_transfers++;
            end else begin
                wait_cnt--;
            end
        end else begin
            apb_resp_i = '0;
            if (apb_req_o.psel) begin
                compare_value("apb_req_o.pwrite", apb_req_o.pwrite, 1'b0);
                setup_req = apb_req_o;
                apb_rng   = next_random(apb_rng);
                wait_cnt  = apb_rng[17:16];
            end
        end
    end

    always @(posedge clk_i) begin
        #1;
        stall_rng = next_random(stall_rng);
        stall_i   = stall_mode & stall_rng[20];
    end

    // A stalled word must stay on fetch_o
    always @(negedge clk_i) begin
        if (rstn_i && hold_prev) begin
            compare_value("fetch_o", fetch_o, prev_fetch);
        end
        hold_prev  = stall_i && fetch_o.valid;
        prev_fetch = fetch_o;
    end

    task automatic wait_fetch(output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
            ok = fetch_o.valid && !stall_i;
        end
        if (!ok) begin
            $display("timeout: no fetched word within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic expect_words(input addr_t start, input int n);
        logic  ok;
        addr_t pc;
        for (int i = 0; i < n; i++) begin
            pc = start + addr_t'(4 * i);
            wait_fetch(ok);
            if (!ok) begin
                return;
            end
            compare_value("fetch_o.pc", fetch_o.pc, pc);
            compare_value("fetch_o.instr", fetch_o.instr, model_word(pc));
            compare_value("fetch_o.access_fault", fetch_o.access_fault, is_fault_line(pc));
        end
    endtask

    // One cycle of flush and/or redirect
    task automatic control_pulse(input logic flush, input logic redirect, input addr_t target);
        @(posedge clk_i);
        #1;
        flush_i          = flush;
        redirect_valid_i = redirect;
        redirect_pc_i    = target;
        @(negedge clk_i);
        if (redirect) begin
            compare_value("fetch_o.valid", fetch_o.valid, 1'b0);
        end
        @(posedge clk_i);
        #1;
        flush_i          = 1'b0;
        redirect_valid_i = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "done" : "failed");
    endtask

    initial begin
        int since;
        int err_before;
        errors           = 0;
        checks           = 0;
        apb_transfers    = 0;
        wait_cnt         = 0;
        apb_rng          = 32'hc2c4_0327;
        stall_rng        = 32'hc2c4_0327;
        stall_mode       = 1'b0;
        hold_prev        = 1'b0;
        prev_fetch       = '0;
        setup_req        = '0;
        rstn_i           = 1'b0;
        stall_i          = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        flush_i          = 1'b0;
        apb_resp_i       = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        err_before = errors;
        expect_words(`FETCH_RESET_PC, 12);
        report_test(1, "sequential fetch", err_before);

        err_before = errors;
        control_pulse(1'b0, 1'b1, 32'h0000_2000);
        since = apb_transfers;
        expect_words(32'h0000_2000, 16);
        compare_value("apb transfers on refill", apb_transfers - since, 16);
        control_pulse(1'b0, 1'b1, 32'h0000_2000);
        since = apb_transfers;
        expect_words(32'h0000_2000, 16);
        compare_value("apb transfers on hit", apb_transfers - since, 0);
        report_test(2, "one refill per line", err_before);

        err_before = errors;
        control_pulse(1'b0, 1'b1, 32'h0000_1108);
        expect_words(32'h0000_1108, 6);
        report_test(3, "redirect", err_before);

        // Line 0x2020 is still cached from the refill test
        err_before = errors;
        since = apb_transfers;
        control_pulse(1'b1, 1'b1, 32'h0000_2020);
        expect_words(32'h0000_2020, 4);
        compare_value("apb transfers after flush", apb_transfers - since, 4);
        report_test(4, "flush", err_before);

        err_before = errors;
        control_pulse(1'b0, 1'b1, 32'h0000_3000);
        since = apb_transfers;
        expect_words(32'h0000_3000, 1);
        compare_value("apb transfers on fault", apb_transfers - since, 4);
        control_pulse(1'b0, 1'b1, 32'h0000_3000);
        since = apb_transfers;
        expect_words(32'h0000_3000, 1);
        compare_value("apb transfers on second fault", apb_transfers - since, 4);
        report_test(5, "access fault", err_before);

        err_before = errors;
        control_pulse(1'b0, 1'b1, 32'h0000_4000);
        @(negedge clk_i);
        stall_mode = 1'b1;
        expect_words(32'h0000_4000, 12);
        stall_mode = 1'b0;
        report_test(6, "stall", err_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
fetch_pkg.sv
icache_pkg.sv
pc_gen.sv
icache_interface.sv
icache_array.sv
fetch_top.sv
tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_front_end

export_include_dirs:
  - .

sources:
  - fetch_pkg.sv
  - icache_pkg.sv
  - pc_gen.sv
  - icache_interface.sv
  - icache_array.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv
